//--- axis_s2m_dma.f
design/dma_stream_pkg.sv
design/dma_mem_pkg.sv
design/s2m_beat_capture.sv
design/s2m_realign.sv
design/s2m_recv_desc.sv
design/axis_s2m_dma.sv
testbench/tb_axis_s2m_dma.sv

//--- Makefile
TOP = tb_axis_s2m_dma

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f axis_s2m_dma.f --top-module $(TOP) -o sim_tb

run: compile
	./obj_dir/sim_tb | awk '{ print } /^Regression passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- testbench/tb_axis_s2m_dma.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axis_s2m_dma;
  import dma_stream_pkg::*;
  import dma_mem_pkg::*;

  localparam int n_pkts     = 40;
  localparam int slot_bytes = 64;
  localparam int beat_limit = 1000;
  localparam int end_limit  = 5000;

  logic                  clk;
  logic                  rst;
  logic [data_width-1:0] s_axis_tdata;
  logic [data_bytes-1:0] s_axis_tkeep;
  logic                  s_axis_tvalid;
  wire                   s_axis_tready;
  logic                  s_axis_tlast;
  logic [7:0]            s_axis_tdest;
  logic [1:0]            s_axis_tuser;
  dma_addr_u             wr_base_addr;
  wire                   mem_wr_en;
  wire  [addr_width-1:0] mem_wr_addr;
  wire  [data_width-1:0] mem_wr_data;
  wire  [data_bytes-1:0] mem_wr_strb;
  wire                   mem_wr_last;
  logic                  mem_wr_ready;
  wire                   recv_desc_valid;
  logic                  recv_desc_ready;
  wire  [addr_width-1:0] recv_desc_addr;
  wire  [len_width-1:0]  recv_desc_len;
  wire  [7:0]            recv_desc_tdest;
  wire  [1:0]            recv_desc_tuser;

  // Packet table, filled before reset is released
  int         pkt_base [n_pkts];
  int         pkt_len  [n_pkts];
  logic [7:0] pkt_dest [n_pkts];
  logic [1:0] pkt_user [n_pkts];

  // Memory model and the bytes each packet should leave behind
  logic [7:0] mem      [0:65535];
  logic       written  [0:65535];
  logic [7:0] exp_mem  [0:65535];

  int errors;
  int desc_cnt;
  int err_mark;
  int wr_pkt;
  int wr_prev;
  bit wr_first;
  bit timed_out;
  int a;
  int bad;

  axis_s2m_dma #(
    .DEST_WIDTH (8),
    .USER_WIDTH (2)
  ) u_axis_s2m_dma (
    .clk             (clk),
    .rst             (rst),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tkeep    (s_axis_tkeep),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tlast    (s_axis_tlast),
    .s_axis_tdest    (s_axis_tdest),
    .s_axis_tuser    (s_axis_tuser),
    .wr_base_addr    (wr_base_addr),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_addr     (mem_wr_addr),
    .mem_wr_data     (mem_wr_data),
    .mem_wr_strb     (mem_wr_strb),
    .mem_wr_last     (mem_wr_last),
    .mem_wr_ready    (mem_wr_ready),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready),
    .recv_desc_addr  (recv_desc_addr),
    .recv_desc_len   (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest),
    .recv_desc_tuser (recv_desc_tuser)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Protocol assertions
  //////////////////////////////////////////////////

  // Outputs are quiet through reset and one cycle beyond it
  assert property (@(posedge clk) rst |=> !mem_wr_en && !mem_wr_last && !recv_desc_valid)
    else begin
      errors++;
      $display("** Error reset: mem_wr_en=%h mem_wr_last=%h recv_desc_valid=%h",
               mem_wr_en, mem_wr_last, recv_desc_valid);
    end

  // The stream input stalls with the memory, and on a final beat while the
  // descriptor is blocked
  assert property (@(posedge clk) disable iff (rst)
    !mem_wr_ready || (s_axis_tlast && recv_desc_valid && !recv_desc_ready)
      |-> !s_axis_tready)
    else begin
      errors++;
      $display("** Error s_axis_tready not stalled: s_axis_tready=%h mem_wr_ready=%h",
               s_axis_tready, mem_wr_ready);
    end

  // A stalled write holds every field
  assert property (@(posedge clk) disable iff (rst)
    mem_wr_en && !mem_wr_ready |=> mem_wr_en && $stable(mem_wr_addr) &&
      $stable(mem_wr_data) && $stable(mem_wr_strb) && $stable(mem_wr_last))
    else begin
      errors++;
      $display("** Error stalled write moved: mem_wr_addr=%h mem_wr_data=%h mem_wr_strb=%h",
               mem_wr_addr, mem_wr_data, mem_wr_strb);
    end

  // A blocked descriptor holds every field
  assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid && $stable(recv_desc_addr) &&
      $stable(recv_desc_len) && $stable(recv_desc_tdest) && $stable(recv_desc_tuser))
    else begin
      errors++;
      $display("** Error blocked descriptor moved: recv_desc_addr=%h recv_desc_len=%h",
               recv_desc_addr, recv_desc_len);
    end

  //////////////////////////////////////////////////
  // Memory and descriptor sinks
  //////////////////////////////////////////////////

  // Ready signals change on the falling edge, like all other inputs
  always @(negedge clk) begin
    mem_wr_ready    = ($urandom % 4) != 0;
    recv_desc_ready = ($urandom % 5) < 3;
  end

  // Writes belong to packets strictly in order, one word apart
  always @(posedge clk) begin
    if (!rst && mem_wr_en && mem_wr_ready) begin
      if (wr_pkt >= n_pkts) begin
        errors++;
        $display("A memory write arrived after every packet had ended");
      end else begin
        assert (mem_wr_addr[lane_bits-1:0] == '0)
          else begin
            errors++;
            $display("** Error mem_wr_addr lane not zero: %h", mem_wr_addr);
          end
        if (wr_first) begin
          assert (int'(mem_wr_addr) == (pkt_base[wr_pkt] & ~(data_bytes - 1)))
            else begin
              errors++;
              $display("** Error first mem_wr_addr: got %h expected %h",
                       mem_wr_addr, pkt_base[wr_pkt] & ~(data_bytes - 1));
            end
        end else begin
          assert (int'(mem_wr_addr) == wr_prev + data_bytes)
            else begin
              errors++;
              $display("** Error mem_wr_addr step: got %h expected %h",
                       mem_wr_addr, wr_prev + data_bytes);
            end
        end
        for (int k = 0; k < data_bytes; k++) begin
          if (mem_wr_strb[k]) begin
            a = int'(mem_wr_addr) + k;
            assert (a >= pkt_base[wr_pkt] && a < pkt_base[wr_pkt] + pkt_len[wr_pkt])
              else begin
                errors++;
                $display("** Error byte write outside packet: mem_wr_addr=%h lane=%h",
                         mem_wr_addr, k);
              end
            mem[a]     = mem_wr_data[k*8 +: 8];
            written[a] = 1'b1;
          end
        end
        wr_prev  = int'(mem_wr_addr);
        wr_first = mem_wr_last;
        if (mem_wr_last) begin
          // The flagged write must be the word holding the final byte
          assert (wr_prev == ((pkt_base[wr_pkt] + pkt_len[wr_pkt] - 1) & ~(data_bytes - 1)))
            else begin
              errors++;
              $display("** Error mem_wr_last on wrong word: mem_wr_addr=%h", mem_wr_addr);
            end
          wr_pkt++;
        end
      end
    end
  end

  // Each accepted descriptor closes one test
  always @(posedge clk) begin
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      if (desc_cnt >= n_pkts) begin
        errors++;
        $display("A descriptor arrived with no packet left to match it");
      end else begin
        assert (int'(recv_desc_addr) == pkt_base[desc_cnt])
          else begin
            errors++;
            $display("** Error recv_desc_addr: got %h expected %h",
                     recv_desc_addr, pkt_base[desc_cnt]);
          end
        assert (int'(recv_desc_len) == pkt_len[desc_cnt])
          else begin
            errors++;
            $display("** Error recv_desc_len: got %h expected %h",
                     recv_desc_len, pkt_len[desc_cnt]);
          end
        assert (recv_desc_tdest == pkt_dest[desc_cnt] && recv_desc_tuser == pkt_user[desc_cnt])
          else begin
            errors++;
            $display("** Error recv_desc_tdest/tuser: got %h/%h expected %h/%h",
                     recv_desc_tdest, recv_desc_tuser, pkt_dest[desc_cnt], pkt_user[desc_cnt]);
          end
        // All of the packet must be in memory by now
        bad = 0;
        for (int i = 0; i < pkt_len[desc_cnt]; i++) begin
          a = pkt_base[desc_cnt] + i;
          if (!written[a] || mem[a] !== exp_mem[a]) begin
            bad++;
          end
        end
        assert (bad == 0)
          else begin
            errors++;
            $display("Packet %0d has %0d bytes missing or wrong in memory", desc_cnt, bad);
          end
        $display("packet %0d base %h len %0d: %s", desc_cnt, pkt_base[desc_cnt],
                 pkt_len[desc_cnt], (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
      end
      desc_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic finish_run();
    $display("%0d of %0d packets done, %0d errors", desc_cnt, n_pkts, errors);
    if (errors == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // Called on a falling edge, returns on a falling edge unless it times out
  task automatic send_packet(input int p);
    int                    nbeats;
    int                    idx;
    int                    t;
    logic [data_width-1:0] data;
    logic [data_bytes-1:0] keep;
    nbeats = (pkt_len[p] + data_bytes - 1) / data_bytes;
    wr_base_addr.flat = addr_width'(pkt_base[p]);
    s_axis_tdest      = pkt_dest[p];
    s_axis_tuser      = pkt_user[p];
    for (int b = 0; b < nbeats; b++) begin
      for (int k = 0; k < data_bytes; k++) begin
        idx     = b * data_bytes + k;
        keep[k] = idx < pkt_len[p];
        // Lanes past the end carry junk that must never reach memory
        data[k*8 +: 8] = keep[k] ? exp_mem[pkt_base[p] + idx] : 8'($urandom);
      end
      s_axis_tdata  = data;
      s_axis_tkeep  = keep;
      s_axis_tlast  = (b == nbeats - 1);
      s_axis_tvalid = 1'b1;
      t = 0;
      forever begin
        @(posedge clk);
        if (s_axis_tready) begin
          break;
        end
        t++;
        if (t >= beat_limit) begin
          $display("Timed out waiting for the DMA to accept a beat of packet %0d", p);
          timed_out = 1'b1;
          return;
        end
      end
      @(negedge clk);
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  initial begin
    int t;
    void'($urandom(2481));
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b0;
    recv_desc_ready = 1'b0;
    errors          = 0;
    desc_cnt        = 0;
    err_mark        = 0;
    wr_pkt          = 0;
    wr_prev         = 0;
    wr_first        = 1'b1;
    timed_out       = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      mem[i]     = 8'h00;
      written[i] = 1'b0;
      exp_mem[i] = 8'h00;
    end
    // Each packet owns a slot, so regions never overlap
    for (int p = 0; p < n_pkts; p++) begin
      pkt_base[p] = p * slot_bytes + int'($urandom % 24);
      pkt_len[p]  = 1 + int'($urandom % 40);
      pkt_dest[p] = 8'($urandom);
      pkt_user[p] = 2'($urandom);
      for (int i = 0; i < pkt_len[p]; i++) begin
        exp_mem[pkt_base[p] + i] = 8'($urandom);
      end
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int p = 0; p < n_pkts; p++) begin
      send_packet(p);
      if (timed_out) begin
        break;
      end
      // Some packets follow back to back, others after a short gap
      if ($urandom % 3 == 0) begin
        repeat (1 + $urandom % 4) @(negedge clk);
      end
    end
    t = 0;
    while (desc_cnt < n_pkts && !timed_out) begin
      @(posedge clk);
      t++;
      if (t >= end_limit) begin
        $display("Timed out waiting for the remaining descriptors");
        timed_out = 1'b1;
      end
    end
    @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

//--- design/axis_s2m_dma.sv
`timescale 1ns/10ps
`default_nettype none

module axis_s2m_dma #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input  wire                                   clk,
  input  wire                                   rst,
  // Stream input
  input  wire  [dma_stream_pkg::data_width-1:0] s_axis_tdata,
  input  wire  [dma_stream_pkg::data_bytes-1:0] s_axis_tkeep,
  input  wire                                   s_axis_tvalid,
  output wire                                   s_axis_tready,
  input  wire                                   s_axis_tlast,
  input  wire  [DEST_WIDTH-1:0]                 s_axis_tdest,
  input  wire  [USER_WIDTH-1:0]                 s_axis_tuser,
  input  wire  dma_mem_pkg::dma_addr_u          wr_base_addr,
  // Memory write port
  output wire                                   mem_wr_en,
  output wire  [dma_mem_pkg::addr_width-1:0]    mem_wr_addr,
  output wire  [dma_stream_pkg::data_width-1:0] mem_wr_data,
  output wire  [dma_stream_pkg::data_bytes-1:0] mem_wr_strb,
  output wire                                   mem_wr_last,
  input  wire                                   mem_wr_ready,
  // Receive descriptor
  output wire                                   recv_desc_valid,
  input  wire                                   recv_desc_ready,
  output wire  [dma_mem_pkg::addr_width-1:0]    recv_desc_addr,
  output wire  [dma_mem_pkg::len_width-1:0]     recv_desc_len,
  output wire  [DEST_WIDTH-1:0]                 recv_desc_tdest,
  output wire  [USER_WIDTH-1:0]                 recv_desc_tuser
);
  import dma_stream_pkg::*;
  import dma_mem_pkg::*;

  //////////////////////////////////////////////////
  // Connections between the three parts
  //////////////////////////////////////////////////

  wire [data_width-1:0] stage_data_1;
  wire [data_width-1:0] stage_data_2;
  wire [data_bytes-1:0] stage_strb_1;
  wire [data_bytes-1:0] stage_strb_2;
  wire [lane_bits:0]    lane_shift;
  wire dma_addr_u       start_addr;
  wire                  first_beat;
  wire                  beat_take;
  wire [len_width-1:0]  pkt_len;
  wire [DEST_WIDTH-1:0] pkt_tdest;
  wire [USER_WIDTH-1:0] pkt_tuser;
  wire                  desc_stall;

  // Input side, which also owns the write enable and the end-of-packet flag
  s2m_beat_capture #(
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) u_capture (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tdest  (s_axis_tdest),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tready (s_axis_tready),
    .wr_base_addr  (wr_base_addr),
    .mem_wr_ready  (mem_wr_ready),
    .desc_stall    (desc_stall),
    .stage_data_1  (stage_data_1),
    .stage_data_2  (stage_data_2),
    .stage_strb_1  (stage_strb_1),
    .stage_strb_2  (stage_strb_2),
    .lane_shift    (lane_shift),
    .start_addr    (start_addr),
    .first_beat    (first_beat),
    .beat_take     (beat_take),
    .mem_wr_en     (mem_wr_en),
    .last_beat     (mem_wr_last),
    .pkt_tdest     (pkt_tdest),
    .pkt_tuser     (pkt_tuser)
  );

  // Data path toward memory and the length count
  s2m_realign u_realign (
    .clk          (clk),
    .rst          (rst),
    .stage_data_1 (stage_data_1),
    .stage_data_2 (stage_data_2),
    .stage_strb_1 (stage_strb_1),
    .stage_strb_2 (stage_strb_2),
    .lane_shift   (lane_shift),
    .start_addr   (start_addr),
    .first_beat   (first_beat),
    .beat_take    (beat_take),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_strb  (mem_wr_strb),
    .mem_wr_addr  (mem_wr_addr),
    .pkt_len      (pkt_len)
  );

  // Output side with the pending slot
  s2m_recv_desc #(
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) u_desc (
    .clk             (clk),
    .rst             (rst),
    .last_beat       (mem_wr_last),
    .beat_take       (beat_take),
    .pkt_len         (pkt_len),
    .start_addr      (start_addr),
    .pkt_tdest       (pkt_tdest),
    .pkt_tuser       (pkt_tuser),
    .desc_stall      (desc_stall),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_addr  (recv_desc_addr),
    .recv_desc_len   (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest),
    .recv_desc_tuser (recv_desc_tuser),
    .recv_desc_ready (recv_desc_ready)
  );

endmodule

`default_nettype wire

//--- design/s2m_recv_desc.sv
`timescale 1ns/10ps
`default_nettype none

module s2m_recv_desc #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                last_beat,
  input  wire                                beat_take,
  input  wire  [dma_mem_pkg::len_width-1:0]  pkt_len,
  input  wire  dma_mem_pkg::dma_addr_u       start_addr,
  input  wire  [DEST_WIDTH-1:0]              pkt_tdest,
  input  wire  [USER_WIDTH-1:0]              pkt_tuser,
  output logic                               desc_stall,
  output logic                               recv_desc_valid,
  output logic [dma_mem_pkg::addr_width-1:0] recv_desc_addr,
  output logic [dma_mem_pkg::len_width-1:0]  recv_desc_len,
  output logic [DEST_WIDTH-1:0]              recv_desc_tdest,
  output logic [USER_WIDTH-1:0]              recv_desc_tuser,
  input  wire                                recv_desc_ready
);
  import dma_mem_pkg::*;

  logic                  new_desc;
  logic                  pend_valid;
  logic [addr_width-1:0] pend_addr;
  logic [len_width-1:0]  pend_len;
  logic [DEST_WIDTH-1:0] pend_tdest;
  logic [USER_WIDTH-1:0] pend_tuser;

  // A packet is complete when its final write is taken by the memory
  assign new_desc = last_beat && beat_take;

  // The register can not take anything new while it is offered and not accepted
  assign desc_stall = recv_desc_valid && !recv_desc_ready;

  //////////////////////////////////////////////////
  // Valid flags
  //////////////////////////////////////////////////

  // The pending slot always goes first, so descriptors leave in packet order
  always_ff @(posedge clk) begin
    if (rst) begin
      recv_desc_valid <= 1'b0;
      pend_valid      <= 1'b0;
    end else if (!desc_stall) begin
      recv_desc_valid <= pend_valid || new_desc;
      pend_valid      <= pend_valid && new_desc;
    end else if (new_desc) begin
      pend_valid <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Descriptor fields
  //////////////////////////////////////////////////

  // Park a finished packet when the register is blocked or already has a
  // packet queued in front of it
  always_ff @(posedge clk) begin
    if (new_desc && (desc_stall || pend_valid)) begin
      pend_addr  <= start_addr.flat;
      pend_len   <= pkt_len;
      pend_tdest <= pkt_tdest;
      pend_tuser <= pkt_tuser;
    end
  end

  // Fields change only when the register is free, so they hold under stall
  always_ff @(posedge clk) begin
    if (!desc_stall && pend_valid) begin
      recv_desc_addr  <= pend_addr;
      recv_desc_len   <= pend_len;
      recv_desc_tdest <= pend_tdest;
      recv_desc_tuser <= pend_tuser;
    end else if (!desc_stall && new_desc) begin
      recv_desc_addr  <= start_addr.flat;
      recv_desc_len   <= pkt_len;
      recv_desc_tdest <= pkt_tdest;
      recv_desc_tuser <= pkt_tuser;
    end
  end

endmodule

`default_nettype wire

//--- design/s2m_realign.sv
`timescale 1ns/10ps
`default_nettype none

module s2m_realign (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire  [dma_stream_pkg::data_width-1:0] stage_data_1,
  input  wire  [dma_stream_pkg::data_width-1:0] stage_data_2,
  input  wire  [dma_stream_pkg::data_bytes-1:0] stage_strb_1,
  input  wire  [dma_stream_pkg::data_bytes-1:0] stage_strb_2,
  input  wire  [dma_stream_pkg::lane_bits:0]    lane_shift,
  input  wire  dma_mem_pkg::dma_addr_u          start_addr,
  input  wire                                   first_beat,
  input  wire                                   beat_take,
  output logic [dma_stream_pkg::data_width-1:0] mem_wr_data,
  output logic [dma_stream_pkg::data_bytes-1:0] mem_wr_strb,
  output logic [dma_mem_pkg::addr_width-1:0]    mem_wr_addr,
  output logic [dma_mem_pkg::len_width-1:0]     pkt_len
);
  import dma_stream_pkg::*;
  import dma_mem_pkg::*;

  logic [2*data_width-1:0] wide_data;
  logic [2*data_bytes-1:0] wide_strb;
  logic [addr_width-1:0]   aligned_addr;
  logic [addr_width-1:0]   next_addr;
  logic [lane_bits:0]      ones;
  logic [len_width-1:0]    len_acc;

  //////////////////////////////////////////////////
  // Byte realignment
  //////////////////////////////////////////////////

  // Stage 1 holds the newer beat and sits above stage 2
  // Shifting right by lane_shift bytes leaves the tail of the older beat in
  // the low lanes and the head of the newer beat above it
  assign wide_data = {stage_data_1, stage_data_2} >> {lane_shift, 3'b000};
  assign wide_strb = {stage_strb_1, stage_strb_2} >> lane_shift;

  assign mem_wr_data = wide_data[data_width-1:0];
  assign mem_wr_strb = wide_strb[data_bytes-1:0];

  //////////////////////////////////////////////////
  // Write address
  //////////////////////////////////////////////////

  // The word that holds the first byte, with the lane bits cleared
  assign aligned_addr = {start_addr.split.word, {lane_bits{1'b0}}};

  assign mem_wr_addr = first_beat ? aligned_addr : next_addr;

  // Each accepted write moves on by one word
  always_ff @(posedge clk) begin
    if (beat_take) begin
      next_addr <= mem_wr_addr + addr_width'(data_bytes);
    end
  end

  //////////////////////////////////////////////////
  // Byte length
  //////////////////////////////////////////////////

  // Strobes may have holes, so count every set bit
  always_comb begin
    ones = '0;
    for (int i = 0; i < data_bytes; i++) begin
      ones = ones + (lane_bits + 1)'(mem_wr_strb[i]);
    end
  end

  // Running length up to and including the write on the port right now
  assign pkt_len = first_beat ? len_width'(ones) : len_acc + len_width'(ones);

  always_ff @(posedge clk) begin
    if (rst) begin
      len_acc <= '0;
    end else if (beat_take) begin
      len_acc <= pkt_len;
    end
  end

endmodule

`default_nettype wire

//--- design/s2m_beat_capture.sv
`timescale 1ns/10ps
`default_nettype none

module s2m_beat_capture #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire  [dma_stream_pkg::data_width-1:0] s_axis_tdata,
  input  wire  [dma_stream_pkg::data_bytes-1:0] s_axis_tkeep,
  input  wire                                   s_axis_tvalid,
  input  wire                                   s_axis_tlast,
  input  wire  [DEST_WIDTH-1:0]                 s_axis_tdest,
  input  wire  [USER_WIDTH-1:0]                 s_axis_tuser,
  output logic                                  s_axis_tready,
  input  wire  dma_mem_pkg::dma_addr_u          wr_base_addr,
  input  wire                                   mem_wr_ready,
  input  wire                                   desc_stall,
  output logic [dma_stream_pkg::data_width-1:0] stage_data_1,
  output logic [dma_stream_pkg::data_width-1:0] stage_data_2,
  output logic [dma_stream_pkg::data_bytes-1:0] stage_strb_1,
  output logic [dma_stream_pkg::data_bytes-1:0] stage_strb_2,
  output logic [dma_stream_pkg::lane_bits:0]    lane_shift,
  output dma_mem_pkg::dma_addr_u                start_addr,
  output logic                                  first_beat,
  output logic                                  beat_take,
  output logic                                  mem_wr_en,
  output logic                                  last_beat,
  output logic [DEST_WIDTH-1:0]                 pkt_tdest,
  output logic [USER_WIDTH-1:0]                 pkt_tuser
);
  import dma_stream_pkg::*;

  localparam logic st_idle = 1'b0;
  localparam logic st_busy = 1'b1;
  // The shift runs from 1 to data_bytes, so it needs one bit above the lane
  localparam int shift_bits = lane_bits + 1;

  logic                  state;
  logic                  beat_acc;
  logic                  latch_info;
  logic [shift_bits-1:0] first_shift;
  logic                  in_last;
  logic                  strb_left;
  logic                  extra_cycle;
  logic                  extra_cycle_r;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign beat_acc  = s_axis_tvalid && s_axis_tready;
  assign beat_take = mem_wr_en && mem_wr_ready;

  // The final stream beat spills into one more word when strobes are left over
  assign extra_cycle = in_last && strb_left;

  // Either the final beat fits in its word, or the extra word is being written
  assign last_beat = mem_wr_en && ((in_last && !extra_cycle) || extra_cycle_r);

  // Input stalls with the memory, during the extra word, and on a final beat
  // while the descriptor register is still blocked
  assign s_axis_tready = mem_wr_ready && !extra_cycle && !(s_axis_tlast && desc_stall);

  // A new packet starts from idle, or back to back with the previous final write
  assign latch_info = ((state == st_idle) || (last_beat && beat_take)) && beat_acc;

  // Bytes from the start of a beat up to the end of the destination word
  assign first_shift = shift_bits'(data_bytes) - shift_bits'(wr_base_addr.split.lane);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else if (state == st_idle) begin
      if (beat_acc) begin
        state <= st_busy;
      end
    end else if (last_beat && beat_take && !beat_acc) begin
      state <= st_idle;
    end
  end

  // Per-packet metadata, held until the next packet starts
  always_ff @(posedge clk) begin
    if (latch_info) begin
      start_addr <= wr_base_addr;
      lane_shift <= first_shift;
      pkt_tdest  <= s_axis_tdest;
      pkt_tuser  <= s_axis_tuser;
    end
  end

  // Work out on acceptance whether a beat has bytes past the shift point
  // On the first beat the new shift is not latched yet
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_left <= 1'b0;
    end else if (extra_cycle && beat_take) begin
      strb_left <= 1'b0;
    end else if (latch_info) begin
      strb_left <= |(s_axis_tkeep >> first_shift);
    end else if (beat_acc) begin
      strb_left <= |(s_axis_tkeep >> lane_shift);
    end
  end

  //////////////////////////////////////////////////
  // Two-stage beat pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (beat_acc) begin
      stage_data_1 <= s_axis_tdata;
    end
    if (beat_take) begin
      stage_data_2 <= stage_data_1;
    end
  end

  // The extra word empties stage 1 so only the spilled bytes remain
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_strb_1 <= '0;
      in_last      <= 1'b0;
    end else if (extra_cycle && beat_take) begin
      stage_strb_1 <= '0;
      in_last      <= 1'b0;
    end else if (beat_acc) begin
      stage_strb_1 <= s_axis_tkeep;
      in_last      <= s_axis_tlast;
    end
  end

  // Stage 2 is cleared by the final write, so a new packet starts with no
  // stale strobes below its first lane
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_strb_2  <= '0;
      extra_cycle_r <= 1'b0;
    end else if (beat_take) begin
      extra_cycle_r <= extra_cycle;
      if (last_beat) begin
        stage_strb_2 <= '0;
      end else begin
        stage_strb_2 <= stage_strb_1;
      end
    end
  end

  // A write is offered after each accepted beat and for the extra word
  // and it holds while the memory is not ready
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_en  <= 1'b0;
      first_beat <= 1'b0;
    end else begin
      mem_wr_en  <= beat_acc || (beat_take && extra_cycle) || (mem_wr_en && !mem_wr_ready);
      first_beat <= latch_info || (first_beat && !mem_wr_ready);
    end
  end

endmodule

`default_nettype wire

//--- design/dma_mem_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Memory side of the DMA
//////////////////////////////////////////////////

// Address and length widths of the memory write port and the descriptor
// The lane split of an address depends on the word width of the stream side
package dma_mem_pkg;

  // Byte address width of the memory write port
  localparam int addr_width = 16;

  // Width of the packet byte length in the receive descriptor
  localparam int len_width = 16;

  // A byte address seen in two ways
  // The flat view is what the descriptor reports back, while the split view
  // gives the word that the write port addresses and the byte lane where the
  // first byte of the packet lands
  typedef union packed {
    // Whole byte address
    logic [addr_width-1:0] flat;

    // Word index over the byte lane
    struct packed {
      logic [addr_width-dma_stream_pkg::lane_bits-1:0] word;
      logic [dma_stream_pkg::lane_bits-1:0]            lane;
    } split;
  } dma_addr_u;

endpackage

`default_nettype wire

//--- design/dma_stream_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Stream side of the DMA
//////////////////////////////////////////////////

// Constants shared by everything that touches a stream beat or a memory word
// The stream beat and the memory word have the same width, so one set of
// constants covers both the tkeep and the memory strobes
package dma_stream_pkg;

  // Width of one AXI-Stream beat in bits
  // This is also the width of one memory word
  localparam int data_width = 64;

  // Bytes per word, which is the tkeep and the strobe width
  localparam int data_bytes = data_width / 8;

  // Bits of a byte-lane index inside one word
  // Three bits for an eight byte word
  localparam int lane_bits = $clog2(data_bytes);

endpackage

`default_nettype wire
